//--- axil_iob_csr.f
logic/axil_iob_pkg.sv
logic/axil2iob.sv
logic/iob_csr_decode.sv
logic/iob_csr_file.sv
logic/iob_read_return.sv
logic/axil_iob_csr_top.sv
bench/axil_iob_csr_checker.sv
bench/axil_iob_csr_tb.sv

//--- bench/axil_iob_csr_checker.sv
`timescale 1ns/1ps

module axil_iob_csr_checker #(
   parameter int ADDR_W = 12
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              exp_push_i,
   input  logic [1:0]        exp_kind_i,
   input  logic [ADDR_W-1:0] exp_addr_i,
   input  logic [31:0]       exp_data_i,
   input  logic              bvalid_i,
   input  logic              bready_i,
   input  logic [1:0]        bresp_i,
   input  logic              rvalid_i,
   input  logic              rready_i,
   input  logic [31:0]       rdata_i,
   input  logic [1:0]        rresp_i,
   output int                pass_cnt_o,
   output int                fail_cnt_o,
   output int                pending_o
);

   // Kinds: write, read with value, read that must be nonzero
   localparam logic [1:0] KIND_WRITE   = 2'd0;
   localparam logic [1:0] KIND_NONZERO = 2'd2;
   localparam int         MAX_AGE      = 16;

   typedef struct packed {
      logic [1:0]        kind;
      logic [ADDR_W-1:0] addr;
      logic [31:0]       data;
   } expect_t;

   // Responses come back in issue order
   expect_t exp_q[$];
   int      age;

   task automatic note_pass(input string msg);
      pass_cnt_o++;
      $display("PASS %s", msg);
   endtask

   task automatic note_error(input string msg);
      fail_cnt_o++;
      $display("ERROR %0t: %s", $time, msg);
   endtask

   always @(posedge clk_i) begin : check_responses
      expect_t cur;
      logic    wr_seen;
      logic    rd_seen;
      if (rst_i) begin
         pass_cnt_o = 0;
         fail_cnt_o = 0;
         age = 0;
         exp_q.delete();
      end else begin
         wr_seen = bvalid_i && bready_i;
         rd_seen = rvalid_i && rready_i;
         if ((wr_seen || rd_seen) && exp_q.size() == 0) begin
            fail_cnt_o++;
            $display("A response arrived with no request outstanding");
         end else if (wr_seen || rd_seen) begin
            cur = exp_q.pop_front();
            age = 0;
            if ((cur.kind == KIND_WRITE) != wr_seen) begin
               fail_cnt_o++;
               $display("Request to 0x%03h was answered on the wrong channel", cur.addr);
            end else if (wr_seen) begin
               if (bresp_i === 2'b00) begin
                  note_pass($sformatf("write 0x%03h bresp OKAY", cur.addr));
               end else begin
                  note_error($sformatf("write 0x%03h bresp %0d, expected OKAY",
                                       cur.addr, bresp_i));
               end
            end else if (rresp_i !== 2'b00) begin
               note_error($sformatf("read 0x%03h rresp %0d, expected OKAY", cur.addr, rresp_i));
            end else if (cur.kind == KIND_NONZERO &&
                         (rdata_i === '0 || $isunknown(rdata_i))) begin
               note_error($sformatf("read 0x%03h returned %08h, expected nonzero",
                                    cur.addr, rdata_i));
            end else if (cur.kind != KIND_NONZERO && rdata_i !== cur.data) begin
               note_error($sformatf("read 0x%03h returned %08h, expected %08h",
                                    cur.addr, rdata_i, cur.data));
            end else begin
               note_pass($sformatf("read 0x%03h returned %08h", cur.addr, rdata_i));
            end
         end else if (exp_q.size() != 0) begin
            age++;
            if (age > MAX_AGE) begin
               cur = exp_q.pop_front();
               age = 0;
               fail_cnt_o++;
               $display("Request to 0x%03h never got a response", cur.addr);
            end
         end
         // A write response must not linger once it was taken
         if (bvalid_i && !wr_seen && (exp_q.size() == 0 || exp_q[0].kind != KIND_WRITE)) begin
            fail_cnt_o++;
            $display("bvalid is high with no write outstanding");
         end
         if (exp_push_i) begin
            exp_q.push_back('{kind: exp_kind_i, addr: exp_addr_i, data: exp_data_i});
         end
         pending_o = exp_q.size();
      end
   end

endmodule

//--- bench/axil_iob_csr_tb.sv
`timescale 1ns/1ps

module axil_iob_csr_tb;

   import axil_iob_pkg::*;

   localparam int         ADDR_W       = 12;
   localparam data_t      ID_VALUE     = 32'hC5A0_0001;
   localparam int         MAX_OPS      = 64;
   localparam logic [1:0] KIND_WRITE   = 2'd0;
   localparam logic [1:0] KIND_READ    = 2'd1;
   localparam logic [1:0] KIND_NONZERO = 2'd2;

   logic              clk;
   logic              rst;
   logic [ADDR_W-1:0] awaddr;
   logic              awvalid;
   logic              awready;
   data_t             wdata;
   strb_t             wstrb;
   logic              wvalid;
   logic              wready;
   resp_t             bresp;
   logic              bvalid;
   logic              bready;
   logic [ADDR_W-1:0] araddr;
   logic              arvalid;
   logic              arready;
   data_t             rdata;
   resp_t             rresp;
   logic              rvalid;
   logic              rready;
   logic              exp_push;
   logic [1:0]        exp_kind;
   logic [ADDR_W-1:0] exp_addr;
   data_t             exp_data;
   int                pass_cnt;
   int                fail_cnt;
   int                pending;
   logic              loaded;
   logic              load_ok;
   int                n_ops;
   logic [7:0]        op_kind [MAX_OPS];
   logic [ADDR_W-1:0] op_addr [MAX_OPS];
   data_t             op_data [MAX_OPS];
   strb_t             op_strb [MAX_OPS];

   always #20 clk = ~clk;

   axil_iob_csr_top #(
      .ADDR_W  (ADDR_W),
      .ID_VALUE(ID_VALUE)
   ) i_dut (
      .clk_i         (clk),
      .rst_i         (rst),
      .axil_awaddr_i (awaddr),
      .axil_awvalid_i(awvalid),
      .axil_awready_o(awready),
      .axil_wdata_i  (wdata),
      .axil_wstrb_i  (wstrb),
      .axil_wvalid_i (wvalid),
      .axil_wready_o (wready),
      .axil_bresp_o  (bresp),
      .axil_bvalid_o (bvalid),
      .axil_bready_i (bready),
      .axil_araddr_i (araddr),
      .axil_arvalid_i(arvalid),
      .axil_arready_o(arready),
      .axil_rdata_o  (rdata),
      .axil_rresp_o  (rresp),
      .axil_rvalid_o (rvalid),
      .axil_rready_i (rready)
   );

   axil_iob_csr_checker #(
      .ADDR_W(ADDR_W)
   ) i_checker (
      .clk_i     (clk),
      .rst_i     (rst),
      .exp_push_i(exp_push),
      .exp_kind_i(exp_kind),
      .exp_addr_i(exp_addr),
      .exp_data_i(exp_data),
      .bvalid_i  (bvalid),
      .bready_i  (bready),
      .bresp_i   (bresp),
      .rvalid_i  (rvalid),
      .rready_i  (rready),
      .rdata_i   (rdata),
      .rresp_i   (rresp),
      .pass_cnt_o(pass_cnt),
      .fail_cnt_o(fail_cnt),
      .pending_o (pending)
   );

   // One operation per line, comment lines start with #
   task automatic load_ops();
      int                fd;
      int                code;
      logic [7:0]        kind;
      logic [1023:0]     rest;
      logic [ADDR_W-1:0] addr;
      data_t             data;
      strb_t             strb;
      load_ok = 1'b0;
      n_ops = 0;
      fd = $fopen("bench/axil_iob_csr_testdata.txt", "r");
      if (fd != 0) begin
         load_ok = 1'b1;
         code = $fscanf(fd, "%s", kind);
         while (code == 1 && n_ops < MAX_OPS) begin
            data = '0;
            strb = '0;
            if (kind == "#") begin
               code = $fgets(rest, fd);
            end else begin
               if (kind == "W") begin
                  code = $fscanf(fd, "%h %h %h", addr, data, strb);
               end else if (kind == "R") begin
                  code = $fscanf(fd, "%h %h", addr, data);
               end else if (kind == "N") begin
                  code = $fscanf(fd, "%h", addr);
               end else begin
                  load_ok = 1'b0;
               end
               op_kind[n_ops] = kind;
               op_addr[n_ops] = addr;
               op_data[n_ops] = data;
               op_strb[n_ops] = strb;
               n_ops++;
            end
            code = $fscanf(fd, "%s", kind);
         end
         $fclose(fd);
      end
   endtask

   // Expectation goes to the checker as a one cycle pulse with the request
   task automatic write_word(input logic [ADDR_W-1:0] addr, input data_t data, input strb_t strb);
      logic hs;
      int   wait_cnt;
      awaddr = addr;
      wdata = data;
      wstrb = strb;
      awvalid = 1'b1;
      wvalid = 1'b1;
      exp_push = 1'b1;
      exp_kind = KIND_WRITE;
      exp_addr = addr;
      exp_data = data;
      hs = 1'b0;
      while (!hs) begin
         @(negedge clk);
         hs = awready && wready;
         @(posedge clk);
         #2;
         exp_push = 1'b0;
      end
      awvalid = 1'b0;
      wvalid = 1'b0;
      bready = 1'b1;
      hs = 1'b0;
      wait_cnt = 0;
      while (!hs && wait_cnt < 20) begin
         @(negedge clk);
         hs = bvalid;
         @(posedge clk);
         #2;
         wait_cnt++;
      end
      bready = 1'b0;
   endtask

   task automatic read_word(input logic [ADDR_W-1:0] addr, input logic [1:0] kind,
                            input data_t expected);
      logic hs;
      araddr = addr;
      arvalid = 1'b1;
      exp_push = 1'b1;
      exp_kind = kind;
      exp_addr = addr;
      exp_data = expected;
      hs = 1'b0;
      while (!hs) begin
         @(negedge clk);
         hs = arready;
         @(posedge clk);
         #2;
         exp_push = 1'b0;
      end
      arvalid = 1'b0;
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b1;
      exp_push = 1'b0;
      exp_kind = KIND_WRITE;
      exp_addr = '0;
      exp_data = '0;
      loaded = 1'b0;
      load_ok = 1'b0;
      load_ops();
      loaded = 1'b1;
      if (!load_ok) begin
         $display("Test data file is missing or holds an unknown operation");
         $display("Testbench failed");
         $finish;
      end else begin
         repeat (2) @(posedge clk);
         #2;
         rst = 1'b0;
         for (int i = 0; i < n_ops; i++) begin
            if (op_kind[i] == "W") begin
               write_word(op_addr[i], op_data[i], op_strb[i]);
            end else if (op_kind[i] == "N") begin
               read_word(op_addr[i], KIND_NONZERO, op_data[i]);
            end else begin
               read_word(op_addr[i], KIND_READ, op_data[i]);
            end
         end
         // Checker drops a lost response after a while, so this drains
         while (pending != 0) begin
            @(posedge clk);
            #2;
         end
         $display("Tests run: %0d, passed: %0d, failed: %0d", n_ops, pass_cnt, fail_cnt);
         if (fail_cnt == 0 && pass_cnt == n_ops) begin
            $display("Testbench passed");
         end else begin
            $display("Testbench failed");
         end
         $finish;
      end
   end

   // Watchdog, 50 cycles per operation
   initial begin
      wait (loaded);
      repeat (n_ops * 50) @(posedge clk);
      $display("timeout: no response");
      $display("Testbench failed");
      $finish;
   end

endmodule

//--- bench/axil_iob_csr_testdata.txt
# Columns: W addr data strobe | R addr expected | N addr (read result must be nonzero)
# All values in hex, addresses are byte addresses in the 12-bit map
R 000 c5a00001
W 000 12345678 f
R 000 c5a00001
W 004 a5a5a5a5 f
R 004 a5a5a5a5
W 004 11223344 3
R 004 a5a53344
W 004 deadbeef 8
R 004 dea53344
W 008 000000f0 f
R 008 000000f0
R 018 00000000
R 808 00000000
W 104 ffffffff f
R 104 00000000
R 004 dea53344
R 008 000000f0
W 008 00000001 1
R 008 00000001
N 00c
W 008 00000000 f
W 00c 00000000 f
R 00c 00000000
R 008 00000000

//--- logic/axil2iob.sv
`timescale 1ns/1ps

module axil2iob #(
   parameter int ADDR_W = 12
) (
   input  logic                    clk_i,
   input  logic                    rst_i,

   // AXI4-Lite slave side
   input  logic [ADDR_W-1:0]       axil_awaddr_i,
   input  logic                    axil_awvalid_i,
   output logic                    axil_awready_o,
   input  axil_iob_pkg::data_t     axil_wdata_i,
   input  axil_iob_pkg::strb_t     axil_wstrb_i,
   input  logic                    axil_wvalid_i,
   output logic                    axil_wready_o,
   output axil_iob_pkg::resp_t     axil_bresp_o,
   output logic                    axil_bvalid_o,
   input  logic                    axil_bready_i,
   input  logic [ADDR_W-1:0]       axil_araddr_i,
   input  logic                    axil_arvalid_i,
   output logic                    axil_arready_o,
   output axil_iob_pkg::data_t     axil_rdata_o,
   output axil_iob_pkg::resp_t     axil_rresp_o,
   output logic                    axil_rvalid_o,
   input  logic                    axil_rready_i,

   // IOb master side
   output axil_iob_pkg::iob_req_t  iob_req_o,
   output logic [ADDR_W-1:0]       iob_addr_o,
   input  axil_iob_pkg::data_t     iob_rdata_i,
   input  logic                    iob_rvalid_i,
   input  logic                    iob_ready_i
);

   import axil_iob_pkg::*;

   logic write_en;
   logic bvalid_set;
   logic rvalid_q;

   assign write_en   = |axil_wstrb_i;
   assign bvalid_set = axil_awvalid_i & axil_wvalid_i;

   // Channel handshakes
   assign axil_awready_o = iob_ready_i & axil_wvalid_i;
   assign axil_wready_o  = iob_ready_i;
   assign axil_arready_o = iob_ready_i;
   assign axil_bresp_o   = RESP_OKAY;
   assign axil_rresp_o   = RESP_OKAY;
   assign axil_rdata_o   = iob_rdata_i;

   // IOb response passes straight through, the flag covers back-pressure
   assign axil_rvalid_o = iob_rvalid_i | rvalid_q;

   // Write address wins over read address
   assign iob_req_o.avalid = (bvalid_set & write_en) | axil_arvalid_i;
   assign iob_req_o.wdata  = axil_wdata_i;
   assign iob_req_o.wstrb  = axil_wvalid_i ? axil_wstrb_i : strb_t'(0);
   assign iob_addr_o       = axil_awvalid_i ? axil_awaddr_i : axil_araddr_i;

   // Write response flag
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         axil_bvalid_o <= 1'b0;
      end else if (bvalid_set | axil_bready_i) begin
         axil_bvalid_o <= bvalid_set;
      end
   end

   // Held read valid, only kept when the master is not ready yet
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rvalid_q <= 1'b0;
      end else if (iob_rvalid_i | axil_rready_i) begin
         rvalid_q <= iob_rvalid_i & ~axil_rready_i;
      end
   end

endmodule

//--- logic/axil_iob_csr_top.sv
`timescale 1ns/1ps

module axil_iob_csr_top #(
   parameter int                  ADDR_W   = 12,
   parameter axil_iob_pkg::data_t ID_VALUE = 32'hC5A0_0001
) (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic [ADDR_W-1:0]    axil_awaddr_i,
   input  logic                 axil_awvalid_i,
   output logic                 axil_awready_o,
   input  axil_iob_pkg::data_t  axil_wdata_i,
   input  axil_iob_pkg::strb_t  axil_wstrb_i,
   input  logic                 axil_wvalid_i,
   output logic                 axil_wready_o,
   output axil_iob_pkg::resp_t  axil_bresp_o,
   output logic                 axil_bvalid_o,
   input  logic                 axil_bready_i,
   input  logic [ADDR_W-1:0]    axil_araddr_i,
   input  logic                 axil_arvalid_i,
   output logic                 axil_arready_o,
   output axil_iob_pkg::data_t  axil_rdata_o,
   output axil_iob_pkg::resp_t  axil_rresp_o,
   output logic                 axil_rvalid_o,
   input  logic                 axil_rready_i
);

   import axil_iob_pkg::*;

   iob_req_t          iob_req;
   logic [ADDR_W-1:0] iob_addr;
   data_t             iob_rdata;
   logic              iob_rvalid;
   logic              iob_ready;
   csr_sel_t          csr_sel;
   data_t             csr_rdata;

   axil2iob #(
      .ADDR_W(ADDR_W)
   ) i_bridge (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .axil_awaddr_i (axil_awaddr_i),
      .axil_awvalid_i(axil_awvalid_i),
      .axil_awready_o(axil_awready_o),
      .axil_wdata_i  (axil_wdata_i),
      .axil_wstrb_i  (axil_wstrb_i),
      .axil_wvalid_i (axil_wvalid_i),
      .axil_wready_o (axil_wready_o),
      .axil_bresp_o  (axil_bresp_o),
      .axil_bvalid_o (axil_bvalid_o),
      .axil_bready_i (axil_bready_i),
      .axil_araddr_i (axil_araddr_i),
      .axil_arvalid_i(axil_arvalid_i),
      .axil_arready_o(axil_arready_o),
      .axil_rdata_o  (axil_rdata_o),
      .axil_rresp_o  (axil_rresp_o),
      .axil_rvalid_o (axil_rvalid_o),
      .axil_rready_i (axil_rready_i),
      .iob_req_o     (iob_req),
      .iob_addr_o    (iob_addr),
      .iob_rdata_i   (iob_rdata),
      .iob_rvalid_i  (iob_rvalid),
      .iob_ready_i   (iob_ready)
   );

   iob_csr_decode #(
      .ADDR_W(ADDR_W)
   ) i_decode (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .iob_req_i  (iob_req),
      .iob_addr_i (iob_addr),
      .iob_ready_i(iob_ready),
      .sel_o      (csr_sel)
   );

   iob_csr_file #(
      .ID_VALUE(ID_VALUE)
   ) i_csr_file (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .sel_i  (csr_sel),
      .rdata_o(csr_rdata)
   );

   iob_read_return i_read_return (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .re_i        (csr_sel.re),
      .rdata_i     (csr_rdata),
      .iob_rdata_o (iob_rdata),
      .iob_rvalid_o(iob_rvalid),
      .iob_ready_o (iob_ready)
   );

endmodule

//--- logic/axil_iob_pkg.sv
package axil_iob_pkg;

   // Data path width, fixed so the structs below have a fixed size
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // One register word and its byte strobes
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;

   // AXI response code
   typedef logic [1:0] resp_t;

   localparam resp_t RESP_OKAY = 2'b00;

   // Register word index, taken from address bits 3:2
   typedef logic [1:0] csr_idx_t;

   localparam csr_idx_t CSR_ID      = 2'd0;
   localparam csr_idx_t CSR_SCRATCH = 2'd1;
   localparam csr_idx_t CSR_CTRL    = 2'd2;
   localparam csr_idx_t CSR_COUNT   = 2'd3;

   // IOb native request, address travels beside it
   typedef struct packed {
      logic  avalid;
      data_t wdata;
      strb_t wstrb;
   } iob_req_t;

   // Decoded register access
   typedef struct packed {
      logic     hit;
      csr_idx_t idx;
      logic     we;
      logic     re;
      data_t    wdata;
      strb_t    wstrb;
   } csr_sel_t;

endpackage

//--- logic/iob_csr_decode.sv
`timescale 1ns/1ps

module iob_csr_decode #(
   parameter int ADDR_W = 12
) (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  axil_iob_pkg::iob_req_t  iob_req_i,
   input  logic [ADDR_W-1:0]       iob_addr_i,
   input  logic                    iob_ready_i,
   output axil_iob_pkg::csr_sel_t  sel_o
);

   import axil_iob_pkg::*;

   logic     accept;
   logic     is_write;
   logic     addr_hit;
   logic     rd_pend_q;
   csr_idx_t idx;

   // Only the four words at the bottom of the map are decoded
   assign idx      = csr_idx_t'(iob_addr_i[3:2]);
   assign addr_hit = ~|iob_addr_i[ADDR_W-1:4];
   assign is_write = |iob_req_i.wstrb;

   // No new request while a read result is still on its way
   assign accept = iob_req_i.avalid & iob_ready_i & ~rd_pend_q;

   // Unmapped reads still strobe so they come back as zero
   assign sel_o.hit   = addr_hit;
   assign sel_o.idx   = idx;
   assign sel_o.we    = accept & is_write & addr_hit;
   assign sel_o.re    = accept & ~is_write;
   assign sel_o.wdata = iob_req_i.wdata;
   assign sel_o.wstrb = iob_req_i.wstrb;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rd_pend_q <= 1'b0;
      end else begin
         rd_pend_q <= accept & ~is_write;
      end
   end

endmodule

//--- logic/iob_csr_file.sv
`timescale 1ns/1ps

module iob_csr_file #(
   parameter axil_iob_pkg::data_t ID_VALUE = 32'hC5A0_0001
) (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  axil_iob_pkg::csr_sel_t  sel_i,
   output axil_iob_pkg::data_t     rdata_o
);

   import axil_iob_pkg::*;

   data_t scratch_q;
   data_t ctrl_q;
   data_t count_q;
   logic  wr_scratch;
   logic  wr_ctrl;
   logic  wr_count;

   // Replace only the strobed bytes
   function automatic data_t merge_bytes(data_t cur, data_t nxt, strb_t strb);
      data_t res;
      res = cur;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = nxt[8*b +: 8];
         end
      end
      return res;
   endfunction

   assign wr_scratch = sel_i.we && (sel_i.idx == CSR_SCRATCH);
   assign wr_ctrl    = sel_i.we && (sel_i.idx == CSR_CTRL);
   assign wr_count   = sel_i.we && (sel_i.idx == CSR_COUNT);

   always_ff @(posedge clk_i) begin
      if (wr_scratch) begin
         scratch_q <= merge_bytes(scratch_q, sel_i.wdata, sel_i.wstrb);
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ctrl_q <= '0;
      end else if (wr_ctrl) begin
         ctrl_q <= merge_bytes(ctrl_q, sel_i.wdata, sel_i.wstrb);
      end
   end

   // Counter, a write of any value clears it
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         count_q <= '0;
      end else if (wr_count) begin
         count_q <= '0;
      end else if (ctrl_q[0]) begin
         count_q <= count_q + 1'b1;
      end
   end

   // Read mux
   always_comb begin
      rdata_o = '0;
      if (sel_i.hit) begin
         case (sel_i.idx)
            CSR_ID:      rdata_o = ID_VALUE;
            CSR_SCRATCH: rdata_o = scratch_q;
            CSR_CTRL:    rdata_o = ctrl_q;
            CSR_COUNT:   rdata_o = count_q;
            default:     rdata_o = '0;
         endcase
      end
   end

endmodule

//--- logic/iob_read_return.sv
`timescale 1ns/1ps

module iob_read_return (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 re_i,
   input  axil_iob_pkg::data_t  rdata_i,
   output axil_iob_pkg::data_t  iob_rdata_o,
   output logic                 iob_rvalid_o,
   output logic                 iob_ready_o
);

   import axil_iob_pkg::*;

   data_t rdata_q;

   // Data is held after the pulse so a stalled AXI master still sees it
   always_ff @(posedge clk_i) begin
      if (re_i) begin
         rdata_q <= rdata_i;
      end
   end

   // One cycle valid pulse per read
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         iob_rvalid_o <= 1'b0;
      end else begin
         iob_rvalid_o <= re_i;
      end
   end

   assign iob_rdata_o = rdata_q;

   // Busy while the result is returned
   assign iob_ready_o = ~iob_rvalid_o;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module axil_iob_csr_tb \
   -f axil_iob_csr.f -o axil_iob_csr_sim \
   && obj_dir/axil_iob_csr_sim > sim.log 2>&1 \
   || echo "Build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "Testbench passed" sim.log && exit 0 || exit 1
